// File: src/pcie_rx_pkg.sv
package pcie_rx_pkg;

    // Stream word, one header or data dword per beat
    typedef logic [31:0] dw_t;

    typedef logic [6:0] fmt_type_t;
    typedef logic [9:0] tlp_len_t;
    typedef logic [15:0] tlp_id_t;

    // Format and type codes, bits [30:24] of header dword 0
    localparam fmt_type_t FT_MWR32 = 7'h40;
    localparam fmt_type_t FT_CPL   = 7'h0A;
    localparam fmt_type_t FT_CPLD  = 7'h4A;

    // One-hot BAR hit from the endpoint core
    localparam int BAR_BITS = 7;

    typedef struct packed {
        tlp_id_t     requester_id;
        logic [7:0]  tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
    } req_dw1_t;

    typedef struct packed {
        tlp_id_t     completer_id;
        logic [2:0]  status;
        logic        bcm;
        logic [11:0] byte_count;
    } cpl_dw1_t;

    // Header dword 1 reads differently for requests and completions
    typedef union packed {
        req_dw1_t req;
        cpl_dw1_t cpl;
    } hdr_dw1_u;

    // FIFO word, 68 bits
    typedef struct packed {
        dw_t        addr;
        dw_t        data;
        logic [3:0] sel;
    } wr_entry_t;

endpackage

// File: src/rx_tlp_decoder.sv
`timescale 1ns/10ps

module rx_tlp_decoder #(
    parameter pcie_rx_pkg::dw_t BAR0_MASK = 32'h0000_0FFF,
    parameter pcie_rx_pkg::dw_t BAR0_BASE = 32'h0000_0000,
    parameter pcie_rx_pkg::dw_t BAR1_MASK = 32'h0000_0FFF,
    parameter pcie_rx_pkg::dw_t BAR1_BASE = 32'h0000_0000
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                rx_valid,
    input  logic                                rx_last,
    input  pcie_rx_pkg::dw_t                    rx_data,
    input  logic [pcie_rx_pkg::BAR_BITS-1:0]    rx_bar,
    output logic                                rx_ready,

    output logic                                push,
    output pcie_rx_pkg::wr_entry_t              push_entry,
    input  logic                                full,

    output logic                                err_valid,
    output logic                                err_unsupported,
    output logic                                err_unexpected,
    output pcie_rx_pkg::tlp_id_t                err_id,
    output logic [7:0]                          err_tag,
    input  logic                                err_ready
);

    typedef enum logic [2:0] {
        ST_HDR0,
        ST_HDR1,
        ST_HDR2,
        ST_DATA,
        ST_SKIP
    } state_t;

    state_t                             state_q;
    pcie_rx_pkg::fmt_type_t             fmt_type_q;
    pcie_rx_pkg::tlp_len_t              len_q;
    logic [pcie_rx_pkg::BAR_BITS-1:0]   bar_q;
    logic [3:0]                         first_be_q;
    logic [3:0]                         last_be_q;
    pcie_rx_pkg::dw_t                   addr_q;
    logic [10:0]                        rem_q;
    logic                               first_q;

    pcie_rx_pkg::hdr_dw1_u              dw1;
    pcie_rx_pkg::dw_t                   xlat_addr;
    logic [3:0]                         beat_sel;
    logic                               beat;
    logic                               is_cpl;
    logic                               hit;

    function automatic logic cpl_code(input pcie_rx_pkg::fmt_type_t ft);
        return (ft == pcie_rx_pkg::FT_CPL) || (ft == pcie_rx_pkg::FT_CPLD);
    endfunction

    assign dw1    = rx_data;
    assign beat   = rx_valid && rx_ready;
    assign is_cpl = cpl_code(fmt_type_q);
    assign hit    = (fmt_type_q == pcie_rx_pkg::FT_MWR32) && (bar_q[0] || bar_q[1]);

    // The FIFO can take only one entry in flight, so a push in progress stalls data
    always_comb begin
        rx_ready = !full;
        if (state_q == ST_HDR0 && err_valid)
            rx_ready = 1'b0;
        if (state_q == ST_DATA && push)
            rx_ready = 1'b0;
    end

    // Keep the offset under the mask, base supplies the upper bits
    always_comb begin
        if (bar_q[0])
            xlat_addr = (rx_data & BAR0_MASK) | (BAR0_BASE & ~BAR0_MASK);
        else
            xlat_addr = (rx_data & BAR1_MASK) | (BAR1_BASE & ~BAR1_MASK);
        xlat_addr[1:0] = 2'b00;
    end

    always_comb begin
        if (first_q)
            beat_sel = first_be_q;
        else if (rem_q == 11'd1)
            beat_sel = last_be_q;
        else
            beat_sel = 4'hF;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_HDR0;
            push      <= 1'b0;
            err_valid <= 1'b0;
        end else begin
            push <= 1'b0;
            if (err_valid && err_ready)
                err_valid <= 1'b0;
            if (beat) begin
                case (state_q)
                    ST_HDR0: begin
                        // Truncated header is dropped as well
                        state_q   <= rx_last ? ST_HDR0 : ST_HDR1;
                        err_valid <= rx_last;
                    end
                    ST_HDR1: begin
                        state_q   <= rx_last ? ST_HDR0 : ST_HDR2;
                        err_valid <= rx_last;
                    end
                    ST_HDR2: begin
                        if (rx_last) begin
                            state_q   <= ST_HDR0;
                            err_valid <= 1'b1;
                        end else if (hit) begin
                            state_q <= ST_DATA;
                        end else begin
                            state_q <= ST_SKIP;
                        end
                    end
                    ST_DATA: begin
                        push <= 1'b1;
                        if (rx_last)
                            state_q <= ST_HDR0;
                    end
                    ST_SKIP: begin
                        if (rx_last) begin
                            state_q   <= ST_HDR0;
                            err_valid <= 1'b1;
                        end
                    end
                    default: state_q <= ST_HDR0;
                endcase
            end
        end
    end

    // Header fields, entry payload and report fields
    always_ff @(posedge clk) begin
        if (beat) begin
            case (state_q)
                ST_HDR0: begin
                    fmt_type_q      <= rx_data[30:24];
                    len_q           <= rx_data[9:0];
                    bar_q           <= rx_bar;
                    err_unexpected  <= cpl_code(rx_data[30:24]);
                    err_unsupported <= !cpl_code(rx_data[30:24]);
                    err_id          <= '0;
                    err_tag         <= '0;
                end
                ST_HDR1: begin
                    first_be_q <= dw1.req.first_be;
                    last_be_q  <= dw1.req.last_be;
                    if (is_cpl) begin
                        err_id <= dw1.cpl.completer_id;
                    end else begin
                        err_id  <= dw1.req.requester_id;
                        err_tag <= dw1.req.tag;
                    end
                end
                ST_HDR2: begin
                    addr_q  <= xlat_addr;
                    rem_q   <= (len_q == '0) ? 11'd1024 : {1'b0, len_q};
                    first_q <= 1'b1;
                    // Completion carries its tag in dword 2
                    if (is_cpl)
                        err_tag <= rx_data[15:8];
                end
                ST_DATA: begin
                    push_entry.addr <= addr_q;
                    push_entry.data <= rx_data;
                    push_entry.sel  <= beat_sel;
                    addr_q          <= addr_q + 32'd4;
                    rem_q           <= rem_q - 11'd1;
                    first_q         <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        !(push && full));

    a_err_hold: assert property (@(posedge clk) disable iff (rst)
        err_valid && !err_ready |=> err_valid &&
            $stable({err_unsupported, err_unexpected, err_id, err_tag}));

endmodule

// File: src/write_fifo.sv
`timescale 1ns/10ps

module write_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        push,
    input  pcie_rx_pkg::wr_entry_t      push_entry,
    output logic                        full,

    input  logic                        pop,
    output logic                        empty,
    output pcie_rx_pkg::wr_entry_t      head_entry
);

    localparam int AW = $clog2(FIFO_DEPTH);

    pcie_rx_pkg::wr_entry_t mem [FIFO_DEPTH];
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [AW:0]            count;
    logic                   do_push;
    logic                   do_pop;

    assign full       = (count == FIFO_DEPTH[AW:0]);
    assign empty      = (count == '0);
    assign do_push    = push && !full;
    assign do_pop     = pop && !empty;
    assign head_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_entry;
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

// File: src/wb_write_master.sv
`timescale 1ns/10ps

module wb_write_master (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        empty,
    input  pcie_rx_pkg::wr_entry_t      head_entry,
    output logic                        pop,

    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output pcie_rx_pkg::dw_t            wb_adr,
    output pcie_rx_pkg::dw_t            wb_dat_w,
    output logic [3:0]                  wb_sel,
    input  logic                        wb_ack
);

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    state_t state_q;

    // Take the head entry as the cycle opens
    assign pop = (state_q == ST_IDLE) && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            wb_cyc  <= 1'b0;
            wb_stb  <= 1'b0;
            wb_we   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (!empty) begin
                        state_q <= ST_WRITE;
                        wb_cyc  <= 1'b1;
                        wb_stb  <= 1'b1;
                        wb_we   <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (wb_ack) begin
                        state_q <= ST_IDLE;
                        wb_cyc  <= 1'b0;
                        wb_stb  <= 1'b0;
                        wb_we   <= 1'b0;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Entry held here, FIFO refills while the slave stalls
    always_ff @(posedge clk) begin
        if (pop) begin
            wb_adr   <= head_entry.addr;
            wb_dat_w <= head_entry.data;
            wb_sel   <= head_entry.sel;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_stb |-> wb_cyc);

    a_stb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && $stable({wb_adr, wb_dat_w, wb_sel}));

endmodule

// File: src/pcie_rx_bridge.sv
`timescale 1ns/10ps

module pcie_rx_bridge #(
    parameter pcie_rx_pkg::dw_t BAR0_MASK  = 32'h0000_0FFF,
    parameter pcie_rx_pkg::dw_t BAR0_BASE  = 32'h0000_0000,
    parameter pcie_rx_pkg::dw_t BAR1_MASK  = 32'h0000_0FFF,
    parameter pcie_rx_pkg::dw_t BAR1_BASE  = 32'h0000_0000,
    parameter int               FIFO_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst,

    // TLP receive stream
    input  logic                                rx_valid,
    input  logic                                rx_last,
    input  pcie_rx_pkg::dw_t                    rx_data,
    input  logic [pcie_rx_pkg::BAR_BITS-1:0]    rx_bar,
    output logic                                rx_ready,

    // Discarded TLP report
    output logic                                err_valid,
    output logic                                err_unsupported,
    output logic                                err_unexpected,
    output pcie_rx_pkg::tlp_id_t                err_id,
    output logic [7:0]                          err_tag,
    input  logic                                err_ready,

    // Wishbone master
    output logic                                wb_cyc,
    output logic                                wb_stb,
    output logic                                wb_we,
    output pcie_rx_pkg::dw_t                    wb_adr,
    output pcie_rx_pkg::dw_t                    wb_dat_w,
    output logic [3:0]                          wb_sel,
    input  logic                                wb_ack
);

    logic                       push;
    pcie_rx_pkg::wr_entry_t     push_entry;
    logic                       full;
    logic                       pop;
    logic                       empty;
    pcie_rx_pkg::wr_entry_t     head_entry;

    rx_tlp_decoder #(
        .BAR0_MASK          ( BAR0_MASK ),
        .BAR0_BASE          ( BAR0_BASE ),
        .BAR1_MASK          ( BAR1_MASK ),
        .BAR1_BASE          ( BAR1_BASE )
    ) u_rx_tlp_decoder (
        .clk                ( clk ),
        .rst                ( rst ),
        .rx_valid           ( rx_valid ),
        .rx_last            ( rx_last ),
        .rx_data            ( rx_data ),
        .rx_bar             ( rx_bar ),
        .rx_ready           ( rx_ready ),
        .push               ( push ),
        .push_entry         ( push_entry ),
        .full               ( full ),
        .err_valid          ( err_valid ),
        .err_unsupported    ( err_unsupported ),
        .err_unexpected     ( err_unexpected ),
        .err_id             ( err_id ),
        .err_tag            ( err_tag ),
        .err_ready          ( err_ready )
    );

    write_fifo #(
        .FIFO_DEPTH         ( FIFO_DEPTH )
    ) u_write_fifo (
        .clk                ( clk ),
        .rst                ( rst ),
        .push               ( push ),
        .push_entry         ( push_entry ),
        .full               ( full ),
        .pop                ( pop ),
        .empty              ( empty ),
        .head_entry         ( head_entry )
    );

    wb_write_master u_wb_write_master (
        .clk                ( clk ),
        .rst                ( rst ),
        .empty              ( empty ),
        .head_entry         ( head_entry ),
        .pop                ( pop ),
        .wb_cyc             ( wb_cyc ),
        .wb_stb             ( wb_stb ),
        .wb_we              ( wb_we ),
        .wb_adr             ( wb_adr ),
        .wb_dat_w           ( wb_dat_w ),
        .wb_sel             ( wb_sel ),
        .wb_ack             ( wb_ack )
    );

endmodule

// File: tb/tb_tests.svh
// Directed tests, each starts and ends just after a rising edge

task automatic wait_for_error();
    int n;
    n = 0;
    while (!err_valid && n < 20) begin
        @(posedge clk);
        #1;
        n++;
    end
    if (!err_valid) begin
        $display("%s: no error report was raised for the discarded TLP", test_name);
        error_count++;
    end
endtask

task automatic check_report(input logic unsupported, input pcie_rx_pkg::tlp_id_t id,
                            input logic [7:0] tag);
    if (!err_valid) begin
        $display("%s: error report dropped before err_ready", test_name);
        error_count++;
    end
    if (err_unsupported !== unsupported) begin
        $display("Error %s: err_unsupported expected %b, actual %b",
                 test_name, unsupported, err_unsupported);
        error_count++;
    end
    if (err_unexpected !== !unsupported) begin
        $display("Error %s: err_unexpected expected %b, actual %b",
                 test_name, !unsupported, err_unexpected);
        error_count++;
    end
    if (err_id !== id) begin
        $display("Error %s: err_id expected %h, actual %h", test_name, id, err_id);
        error_count++;
    end
    if (err_tag !== tag) begin
        $display("Error %s: err_tag expected %h, actual %h", test_name, tag, err_tag);
        error_count++;
    end
endtask

task automatic release_error();
    err_ready = 1'b1;
    @(posedge clk);
    #1;
    err_ready = 1'b0;
    if (err_valid) begin
        $display("%s: error report still pending after err_ready", test_name);
        error_count++;
    end
endtask

task automatic reset_values();
    begin_test("reset_values");
    if (rx_ready !== 1'b1) begin
        $display("Error %s: rx_ready expected 1, actual %b", test_name, rx_ready);
        error_count++;
    end
    if (wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
        $display("Error %s: cyc/stb expected 00, actual %b%b", test_name, wb_cyc, wb_stb);
        error_count++;
    end
    if (err_valid !== 1'b0) begin
        $display("Error %s: err_valid expected 0, actual %b", test_name, err_valid);
        error_count++;
    end
    end_test();
endtask

task automatic single_dword_bar0();
    begin_test("single_dword_bar0");
    queue_mem_write(0, $urandom, 1, 4'(1 + $urandom % 15), 4'h0, 1'b1);
    send_tlp(7'b000_0001);
    wait_for_writes(1);
    compare_writes();
    end_test();
endtask

task automatic burst_bar1();
    begin_test("burst_bar1");
    queue_mem_write(1, $urandom, 4, 4'(1 + $urandom % 15), 4'(1 + $urandom % 15), 1'b1);
    send_tlp(7'b000_0010);
    wait_for_writes(4);
    compare_writes();
    end_test();
endtask

// Slow slave fills the FIFO and pushes back on the stream
task automatic backpressure_stream();
    begin_test("backpressure_stream");
    ack_min    = 5;
    ack_max    = 5;
    stall_seen = 1'b0;
    queue_mem_write(0, $urandom, 4, 4'hF, 4'h3, 1'b1);
    send_tlp(7'b000_0001);
    queue_mem_write(1, $urandom, 4, 4'hC, 4'hF, 1'b1);
    send_tlp(7'b000_0010);
    queue_mem_write(0, $urandom, 4, 4'h6, 4'h1, 1'b1);
    send_tlp(7'b000_0001);
    wait_for_writes(12);
    compare_writes();
    if (!stall_seen) begin
        $display("%s: rx_ready never dropped during the stream", test_name);
        error_count++;
    end
    ack_min = 0;
    ack_max = 5;
    end_test();
endtask

task automatic read_unsupported();
    pcie_rx_pkg::tlp_id_t id;
    logic [7:0]           tag;
    begin_test("read_unsupported");
    id  = 16'($urandom);
    tag = 8'($urandom);
    // Memory read, 3-dword header, no data
    tx_q.push_back({1'b0, 7'h00, 14'h0, 10'd1});
    tx_q.push_back({id, tag, 4'h0, 4'hF});
    tx_q.push_back(BAR0_BASE | 32'h0000_0040);
    send_tlp(7'b000_0001);
    wait_for_error();
    check_report(1'b1, id, tag);
    repeat (5) begin
        @(posedge clk);
        #1;
        check_report(1'b1, id, tag);
    end
    release_error();
    wait_for_writes(0);
    compare_writes();
    end_test();
endtask

task automatic completion_unexpected();
    pcie_rx_pkg::tlp_id_t cpl_id;
    pcie_rx_pkg::tlp_id_t req_id;
    logic [7:0]           tag;
    begin_test("completion_unexpected");
    cpl_id = 16'($urandom);
    req_id = 16'($urandom);
    tag    = 8'($urandom);
    tx_q.push_back({1'b0, pcie_rx_pkg::FT_CPLD, 14'h0, 10'd2});
    tx_q.push_back({cpl_id, 3'b000, 1'b0, 12'd8});
    tx_q.push_back({req_id, tag, 1'b0, 7'h00});
    tx_q.push_back($urandom);
    tx_q.push_back($urandom);
    send_tlp('0);
    wait_for_error();
    check_report(1'b0, cpl_id, tag);
    release_error();
    wait_for_writes(0);
    compare_writes();
    end_test();
endtask

task automatic bar2_then_bar0();
    begin_test("bar2_then_bar0");
    queue_mem_write(0, $urandom, 2, 4'hF, 4'hF, 1'b0);
    send_tlp(7'b000_0100);
    wait_for_error();
    check_report(1'b1, sent_id, sent_tag);
    release_error();
    queue_mem_write(0, $urandom, 2, 4'h8, 4'h7, 1'b1);
    send_tlp(7'b000_0001);
    wait_for_writes(2);
    compare_writes();
    end_test();
endtask

// File: tb/tb_pcie_rx_bridge.sv
`timescale 1ns/10ps

module tb_pcie_rx_bridge;

    localparam pcie_rx_pkg::dw_t BAR0_BASE = 32'h1000_0000;
    localparam pcie_rx_pkg::dw_t BAR0_MASK = 32'h0000_0FFF;
    localparam pcie_rx_pkg::dw_t BAR1_BASE = 32'h2000_0000;
    localparam pcie_rx_pkg::dw_t BAR1_MASK = 32'h0000_00FF;
    localparam int               FIFO_DEPTH = 4;

    // Worst-case cycles of each test with reset added to the first one
    localparam int TEST_CYCLES = 20 + 40 + 60 + 150 + 40 + 40 + 70;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic                             clk = 1'b0;
    logic                             rst;
    logic                             rx_valid;
    logic                             rx_last;
    pcie_rx_pkg::dw_t                 rx_data;
    logic [pcie_rx_pkg::BAR_BITS-1:0] rx_bar;
    logic                             rx_ready;
    logic                             err_valid;
    logic                             err_unsupported;
    logic                             err_unexpected;
    pcie_rx_pkg::tlp_id_t             err_id;
    logic [7:0]                       err_tag;
    logic                             err_ready;
    logic                             wb_cyc;
    logic                             wb_stb;
    logic                             wb_we;
    pcie_rx_pkg::dw_t                 wb_adr;
    pcie_rx_pkg::dw_t                 wb_dat_w;
    logic [3:0]                       wb_sel;
    logic                             wb_ack = 1'b0;

    // Slave model state and write log
    logic             in_cycle = 1'b0;
    int               ack_wait = 0;
    int               ack_min = 0;
    int               ack_max = 5;
    pcie_rx_pkg::dw_t log_addr[$];
    pcie_rx_pkg::dw_t log_data[$];
    logic [3:0]       log_sel[$];
    logic             log_we[$];

    // Stimulus and expected entries
    pcie_rx_pkg::dw_t     tx_q[$];
    pcie_rx_pkg::dw_t     exp_addr[$];
    pcie_rx_pkg::dw_t     exp_data[$];
    logic [3:0]           exp_sel[$];
    pcie_rx_pkg::tlp_id_t sent_id;
    logic [7:0]           sent_tag;
    logic                 stall_seen;

    string test_name;
    int    start_errors;
    int    error_count = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;

    always #50 clk = ~clk;

    pcie_rx_bridge #(
        .BAR0_MASK  ( BAR0_MASK ),
        .BAR0_BASE  ( BAR0_BASE ),
        .BAR1_MASK  ( BAR1_MASK ),
        .BAR1_BASE  ( BAR1_BASE ),
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_pcie_rx_bridge (
        .clk             ( clk ),
        .rst             ( rst ),
        .rx_valid        ( rx_valid ),
        .rx_last         ( rx_last ),
        .rx_data         ( rx_data ),
        .rx_bar          ( rx_bar ),
        .rx_ready        ( rx_ready ),
        .err_valid       ( err_valid ),
        .err_unsupported ( err_unsupported ),
        .err_unexpected  ( err_unexpected ),
        .err_id          ( err_id ),
        .err_tag         ( err_tag ),
        .err_ready       ( err_ready ),
        .wb_cyc          ( wb_cyc ),
        .wb_stb          ( wb_stb ),
        .wb_we           ( wb_we ),
        .wb_adr          ( wb_adr ),
        .wb_dat_w        ( wb_dat_w ),
        .wb_sel          ( wb_sel ),
        .wb_ack          ( wb_ack )
    );

    // Wishbone slave that acks each write after ack_min to ack_max cycles
    always @(posedge clk) begin
        #1;
        if (rst) begin
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                ack_wait = ack_min + int'($urandom % (ack_max - ack_min + 1));
            end
            if (ack_wait == 0) begin
                log_addr.push_back(wb_adr);
                log_data.push_back(wb_dat_w);
                log_sel.push_back(wb_sel);
                log_we.push_back(wb_we);
                wb_ack   = 1'b1;
                in_cycle = 1'b0;
            end else begin
                ack_wait--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // Holds one beat until rx_ready and returns just after the edge that takes it
    task automatic drive_beat(input pcie_rx_pkg::dw_t data, input logic last,
                              input logic [pcie_rx_pkg::BAR_BITS-1:0] bar);
        int waits;
        waits    = 0;
        rx_valid = 1'b1;
        rx_data  = data;
        rx_last  = last;
        rx_bar   = bar;
        while (!rx_ready) begin
            waits++;
            @(posedge clk);
            #1;
        end
        // A pushed data beat blocks rx_ready for one cycle only
        if (waits > 1)
            stall_seen = 1'b1;
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        rx_bar   = '0;
    endtask

    task automatic send_tlp(input logic [pcie_rx_pkg::BAR_BITS-1:0] bar);
        int i;
        for (i = 0; i < tx_q.size(); i++)
            drive_beat(tx_q[i], i == tx_q.size() - 1, (i == 0) ? bar : '0);
        tx_q.delete();
    endtask

    // Queues a 3-dword memory write and its expected entries when it should hit
    task automatic queue_mem_write(input int bar_idx, input pcie_rx_pkg::dw_t addr,
                                   input int ndw, input logic [3:0] first_be,
                                   input logic [3:0] last_be, input logic expect_hit);
        pcie_rx_pkg::dw_t base;
        pcie_rx_pkg::dw_t mask;
        pcie_rx_pkg::dw_t data;
        int               i;
        base     = (bar_idx == 0) ? BAR0_BASE : BAR1_BASE;
        mask     = (bar_idx == 0) ? BAR0_MASK : BAR1_MASK;
        sent_id  = 16'($urandom);
        sent_tag = 8'($urandom);
        tx_q.push_back({1'b0, pcie_rx_pkg::FT_MWR32, 14'h0, 10'(ndw)});
        tx_q.push_back({sent_id, sent_tag, last_be, first_be});
        tx_q.push_back(addr);
        for (i = 0; i < ndw; i++) begin
            data = $urandom;
            tx_q.push_back(data);
            if (expect_hit) begin
                exp_addr.push_back((base & ~mask) + (addr & mask & 32'hFFFF_FFFC) + 32'(4 * i));
                exp_data.push_back(data);
                if (ndw == 1 || i == 0)
                    exp_sel.push_back(first_be);
                else if (i == ndw - 1)
                    exp_sel.push_back(last_be);
                else
                    exp_sel.push_back(4'hF);
            end
        end
    endtask

    task automatic wait_for_writes(input int n);
        while (log_addr.size() < n) begin
            @(posedge clk);
            #1;
        end
        // Idle time so that stray writes also show up in the log
        repeat (10) @(posedge clk);
        #1;
    endtask

    task automatic compare_writes();
        int i;
        if (log_addr.size() != exp_addr.size()) begin
            $display("Error %s: write count expected %0d, actual %0d",
                     test_name, exp_addr.size(), log_addr.size());
            error_count++;
        end
        for (i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
            if (log_addr[i] !== exp_addr[i]) begin
                $display("Error %s: write %0d address expected %h, actual %h",
                         test_name, i, exp_addr[i], log_addr[i]);
                error_count++;
            end
            if (log_data[i] !== exp_data[i]) begin
                $display("Error %s: write %0d data expected %h, actual %h",
                         test_name, i, exp_data[i], log_data[i]);
                error_count++;
            end
            if (log_sel[i] !== exp_sel[i]) begin
                $display("Error %s: write %0d select expected %h, actual %h",
                         test_name, i, exp_sel[i], log_sel[i]);
                error_count++;
            end
            if (log_we[i] !== 1'b1) begin
                $display("Error %s: write %0d we expected 1, actual %b", test_name, i, log_we[i]);
                error_count++;
            end
        end
        log_addr.delete();
        log_data.delete();
        log_sel.delete();
        log_we.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_sel.delete();
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        start_errors = error_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_count == start_errors) begin
            $display("%s: PASS", test_name);
        end else begin
            tests_failed++;
            $display("%s: FAIL", test_name);
        end
    endtask

    `include "tb_tests.svh"

    initial begin
        void'($urandom(4));
        rst        = 1'b1;
        rx_valid   = 1'b0;
        rx_last    = 1'b0;
        rx_data    = '0;
        rx_bar     = '0;
        err_ready  = 1'b0;
        stall_seen = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_values();
        single_dword_bar0();
        burst_bar1();
        backpressure_stream();
        read_unsupported();
        completion_unexpected();
        bar2_then_bar0();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tb
src/pcie_rx_pkg.sv
src/rx_tlp_decoder.sv
src/write_fifo.sv
src/wb_write_master.sv
src/pcie_rx_bridge.sv
tb/tb_pcie_rx_bridge.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_pcie_rx_bridge \
    -f filelist.f \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
exit 1
